//--- src/vic_pkg.sv
`default_nettype none

package vic_pkg;

  // video standard, also the chip model
  typedef enum logic [1:0] {
    CHIP_NTSC = 2'd0,
    CHIP_PAL  = 2'd1
  } chip_e;

  // register map, the address doubles as the bus opcode
  typedef enum logic [5:0] {
    REG_CTRL1      = 6'h11,
    REG_RASTER     = 6'h12,
    REG_IRQ_STATUS = 6'h19,
    REG_IRQ_ENABLE = 6'h1a,
    REG_BORDER     = 6'h20,
    REG_BG0        = 6'h21
  } reg_addr_e;

  // one sampled state of the multiplexed cpu bus
  typedef struct packed {
    logic       ce;     // active low
    logic       rw;     // 1 = read
    logic [5:0] addr;
    logic [7:0] wdata;
  } bus_req_t;

  // raster position
  typedef struct packed {
    logic [6:0] cycle;  // phi cycle in line
    logic [8:0] line;
    logic       phi;    // high during phi high
  } raster_t;

  typedef struct packed {
    logic       active;
    logic       hsync;
    logic       vsync;
    logic [5:0] red;
    logic [5:0] green;
    logic [5:0] blue;
  } video_t;

  // {red, green, blue} per color index, 6 bits a channel
  localparam logic [17:0] palette [16] = '{
    {6'd0,  6'd0,  6'd0 },  // black
    {6'd63, 6'd63, 6'd63},  // white
    {6'd26, 6'd13, 6'd10},  // red
    {6'd28, 6'd41, 6'd44},  // cyan
    {6'd27, 6'd15, 6'd33},  // purple
    {6'd22, 6'd35, 6'd16},  // green
    {6'd13, 6'd10, 6'd30},  // blue
    {6'd46, 6'd49, 6'd27},  // yellow
    {6'd27, 6'd19, 6'd9 },  // orange
    {6'd16, 6'd14, 6'd0 },  // brown
    {6'd38, 6'd25, 6'd22},  // light red
    {6'd17, 6'd17, 6'd17},  // dark grey
    {6'd27, 6'd27, 6'd27},  // mid grey
    {6'd38, 6'd52, 6'd33},  // light green
    {6'd27, 6'd23, 6'd45},  // light blue
    {6'd37, 6'd37, 6'd37}   // light grey
  };

endpackage

`default_nettype wire

//--- src/chip_select.sv
`timescale 1ns/1ps
`default_nettype none

module chip_select (
  input  logic           clk_col4x_ntsc,
  input  logic           rst,
  input  logic           standard_sw,  // toggle switch, async
  input  logic           cfg_reset,    // async, forces ntsc
  output vic_pkg::chip_e chip
);
  import vic_pkg::*;

  logic sw_s1, sw_s2;    // switch synchronizer
  logic sw_d;            // edge register
  logic cfg_s1, cfg_s2;  // cfg_reset synchronizer
  logic sw_rise;

  assign sw_rise = sw_s2 & ~sw_d;

  always_ff @(posedge clk_col4x_ntsc) begin
    if (rst) begin
      sw_s1  <= 1'b0;
      sw_s2  <= 1'b0;
      sw_d   <= 1'b0;
      cfg_s1 <= 1'b0;
      cfg_s2 <= 1'b0;
      chip   <= CHIP_NTSC;
    end else begin
      sw_s1  <= standard_sw;
      sw_s2  <= sw_s1;
      sw_d   <= sw_s2;
      cfg_s1 <= cfg_reset;
      cfg_s2 <= cfg_s1;
      if (cfg_s2) chip <= CHIP_NTSC;  // config reset wins over the switch
      else if (sw_rise) chip <= (chip == CHIP_NTSC) ? CHIP_PAL : CHIP_NTSC;
    end
  end

endmodule

`default_nettype wire

//--- src/raster_timer.sv
`timescale 1ns/1ps
`default_nettype none

module raster_timer #(
  parameter int CYCLES_NTSC  = 65,
  parameter int CYCLES_PAL   = 63,
  parameter int LINES_NTSC   = 263,
  parameter int LINES_PAL    = 312,
  parameter int DOTS_PER_PHI = 8,
  parameter int HSYNC_CYCLES = 4,
  parameter int VSYNC_LINES  = 3
) (
  input  logic             clk_col4x_ntsc,
  input  logic             rst,
  input  vic_pkg::chip_e   chip,
  output vic_pkg::raster_t raster,
  output logic             clk_phi,
  output logic             phi_fall,  // last clock of the phi period
  output logic             hsync,
  output logic             vsync
);
  import vic_pkg::*;

  localparam int DOT_W = $clog2(DOTS_PER_PHI);

  logic [DOT_W-1:0] dot_cnt;
  logic [6:0]       cyc_q;
  logic [8:0]       line_q;
  logic [6:0]       cyc_lim;   // cycles per line, latched per frame
  logic [8:0]       line_lim;  // lines per frame
  logic             last_cyc;
  logic             last_line;

  // phi low for the first half of the period
  assign clk_phi  = dot_cnt >= DOT_W'(DOTS_PER_PHI / 2);
  assign phi_fall = dot_cnt == DOT_W'(DOTS_PER_PHI - 1);

  assign last_cyc  = cyc_q == cyc_lim - 7'd1;
  assign last_line = line_q == line_lim - 9'd1;

  assign hsync = cyc_q < 7'(HSYNC_CYCLES);
  assign vsync = line_q < 9'(VSYNC_LINES);

  assign raster = '{cycle: cyc_q, line: line_q, phi: clk_phi};

  always_ff @(posedge clk_col4x_ntsc) begin
    if (rst) begin
      // start in the phi high half of cycle 0, so no refresh slot is open
      dot_cnt  <= DOT_W'(DOTS_PER_PHI / 2);
      cyc_q    <= '0;
      line_q   <= '0;
      cyc_lim  <= 7'(CYCLES_NTSC);
      line_lim <= 9'(LINES_NTSC);
    end else begin
      dot_cnt <= phi_fall ? '0 : dot_cnt + 1'b1;
      if (phi_fall) begin
        if (last_cyc) begin
          cyc_q <= '0;
          if (last_line) begin
            line_q <= '0;
            // frame wrap, pick up a pending chip change here
            cyc_lim  <= (chip == CHIP_PAL) ? 7'(CYCLES_PAL) : 7'(CYCLES_NTSC);
            line_lim <= (chip == CHIP_PAL) ? 9'(LINES_PAL) : 9'(LINES_NTSC);
          end else begin
            line_q <= line_q + 9'd1;
          end
        end else begin
          cyc_q <= cyc_q + 7'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
  input  logic              clk_col4x_ntsc,
  input  logic              rst,
  input  vic_pkg::bus_req_t bus,       // sampled one clock earlier
  input  vic_pkg::raster_t  raster,
  input  logic              phi_fall,
  output logic [7:0]        rdata,
  output logic              rd_en,     // drive dbl
  output logic              irq_n,
  output logic [3:0]        border,
  output logic [3:0]        bg
);
  import vic_pkg::*;

  logic [8:0] raster_cmp;  // bit 8 lives in ctrl1 bit 7
  logic       irq_en;
  logic       irq_flag;
  logic [8:0] line_q;      // previous line, for change detect
  logic       line_hit;
  logic       irq_any;
  logic       wr_stb;
  logic       bus_rd;
  logic [7:0] rd_mux;
  reg_addr_e  addr;

  assign addr    = reg_addr_e'(bus.addr);
  assign wr_stb  = phi_fall & ~bus.ce & ~bus.rw;  // 6510 commits at phi fall
  assign bus_rd  = ~bus.ce & bus.rw;
  assign irq_any = irq_flag & irq_en;

  // new line equal to compare
  assign line_hit = (raster.line != line_q) && (raster.line == raster_cmp);

  always_comb begin
    case (addr)
      REG_CTRL1:      rd_mux = {raster.line[8], 7'h7f};
      REG_RASTER:     rd_mux = raster.line[7:0];
      REG_IRQ_STATUS: rd_mux = {irq_any, 6'h3f, irq_flag};
      REG_IRQ_ENABLE: rd_mux = {7'h7f, irq_en};
      REG_BORDER:     rd_mux = {4'hf, border};  // upper nibble unused
      REG_BG0:        rd_mux = {4'hf, bg};
      default:        rd_mux = 8'hff;           // unmapped
    endcase
  end

  // read data follows the sample by one clock
  always_ff @(posedge clk_col4x_ntsc) begin
    rdata <= rd_mux;
  end

  always_ff @(posedge clk_col4x_ntsc) begin
    if (rst) begin
      rd_en      <= 1'b0;
      irq_n      <= 1'b1;
      irq_en     <= 1'b0;
      irq_flag   <= 1'b0;
      raster_cmp <= '0;
      line_q     <= '0;
      border     <= '0;
      bg         <= '0;
    end else begin
      line_q <= raster.line;
      // drive only in phi high, drop on ce rise or phi fall
      rd_en  <= bus_rd & raster.phi & ~phi_fall;
      irq_n  <= ~irq_any;

      if (wr_stb) begin
        case (addr)
          REG_CTRL1:      raster_cmp[8] <= bus.wdata[7];
          REG_RASTER:     raster_cmp[7:0] <= bus.wdata;
          REG_IRQ_ENABLE: irq_en <= bus.wdata[0];
          REG_BORDER:     border <= bus.wdata[3:0];
          REG_BG0:        bg <= bus.wdata[3:0];
          default:        ;
        endcase
      end

      // set beats a same-clock acknowledge
      if (line_hit) irq_flag <= 1'b1;
      else if (wr_stb && addr == REG_IRQ_STATUS && bus.wdata[0]) irq_flag <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/refresh_gen.sv
`timescale 1ns/1ps
`default_nettype none

module refresh_gen #(
  parameter int REFRESH_SLOTS = 5
) (
  input  logic             clk_col4x_ntsc,
  input  logic             rst,
  input  vic_pkg::raster_t raster,
  output logic [11:0]      ref_addr,
  output logic             ab_en,     // drive adl/adh
  output logic             ras
);

  logic [7:0] row;   // refresh row counter
  logic       ab_q;  // slot open last clock

  // refresh only in phi low of the first cycles of a line
  assign ab_en = ~raster.phi && (raster.cycle < 7'(REFRESH_SLOTS));
  assign ras   = ~ab_en;

  assign ref_addr = {4'hf, row};  // top bits read high like the real part

  always_ff @(posedge clk_col4x_ntsc) begin
    if (rst) begin
      row  <= '0;
      ab_q <= 1'b0;
    end else begin
      ab_q <= ab_en;
      if (ab_q && !ab_en) row <= row + 8'd1;  // slot just closed, wraps at 256
    end
  end

endmodule

`default_nettype wire

//--- src/pixel_out.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_out #(
  parameter int DISP_FIRST_LINE  = 51,
  parameter int DISP_LAST_LINE   = 250,
  parameter int DISP_FIRST_CYCLE = 16,
  parameter int DISP_LAST_CYCLE  = 55
) (
  input  logic             clk_col4x_ntsc,
  input  logic             rst,
  input  vic_pkg::raster_t raster,
  input  logic             hsync,
  input  logic             vsync,
  input  logic [3:0]       border,
  input  logic [3:0]       bg,
  output vic_pkg::video_t  video
);
  import vic_pkg::*;

  logic        blank;
  logic        in_line;
  logic        in_cyc;
  logic [17:0] rgb;  // {red, green, blue}

  assign blank   = hsync | vsync;
  assign in_line = (raster.line >= 9'(DISP_FIRST_LINE)) &&
                   (raster.line <= 9'(DISP_LAST_LINE));
  assign in_cyc  = (raster.cycle >= 7'(DISP_FIRST_CYCLE)) &&
                   (raster.cycle <= 7'(DISP_LAST_CYCLE));

  always_comb begin
    if (blank) rgb = '0;
    else if (in_line && in_cyc) rgb = palette[bg];  // display window
    else rgb = palette[border];
  end

  // syncs share the register with the color so they stay aligned
  always_ff @(posedge clk_col4x_ntsc) begin
    if (rst) begin
      video <= '0;
    end else begin
      video.active <= ~blank;
      video.hsync  <= hsync;
      video.vsync  <= vsync;
      video.red    <= rgb[17:12];
      video.green  <= rgb[11:6];
      video.blue   <= rgb[5:0];
    end
  end

endmodule

`default_nettype wire

//--- src/vic_top.sv
`timescale 1ns/1ps
`default_nettype none

module vic_top #(
  parameter int CYCLES_NTSC      = 65,
  parameter int CYCLES_PAL       = 63,
  parameter int LINES_NTSC       = 263,
  parameter int LINES_PAL        = 312,
  parameter int DOTS_PER_PHI     = 8,
  parameter int HSYNC_CYCLES     = 4,
  parameter int VSYNC_LINES      = 3,
  parameter int DISP_FIRST_LINE  = 51,
  parameter int DISP_LAST_LINE   = 250,
  parameter int DISP_FIRST_CYCLE = 16,
  parameter int DISP_LAST_CYCLE  = 55,
  parameter int REFRESH_SLOTS    = 5
) (
  input  logic       clk_col4x_ntsc,
  input  logic       rst,
  input  logic       cfg_reset,
  input  logic       standard_sw,
  input  logic       ce,          // low = selected
  input  logic       rw,          // low = write
  inout  tri   [5:0] adl,         // low address, shared with refresh
  inout  tri   [7:0] dbl,
  output tri   [5:0] adh,
  output logic       cpu_reset,
  output logic       clk_phi,
  output logic       irq,
  output logic       ras,
  output logic       hsync,
  output logic       vsync,
  output logic       active,
  output logic [5:0] red,
  output logic [5:0] green,
  output logic [5:0] blue
);
  import vic_pkg::*;

  chip_e       chip;
  raster_t     raster;
  bus_req_t    bus_q;
  video_t      video;
  logic        phi_fall;
  logic        hsync_raw, vsync_raw;  // unregistered syncs from the timer
  logic [7:0]  rdata;
  logic        rd_en;
  logic        irq_n;
  logic [3:0]  border, bg;
  logic [11:0] ref_addr;
  logic        ab_en;

  assign cpu_reset = rst;  // holds the cpu while we reset
  assign irq       = irq_n;

  // sample the cpu bus every clock
  always_ff @(posedge clk_col4x_ntsc) begin
    if (rst) bus_q <= '{ce: 1'b1, rw: 1'b1, addr: '0, wdata: '0};
    else bus_q <= '{ce: ce, rw: rw, addr: adl, wdata: dbl};
  end

  chip_select u_chip (
    .clk_col4x_ntsc, .rst, .standard_sw, .cfg_reset, .chip
  );

  raster_timer #(
    .CYCLES_NTSC(CYCLES_NTSC), .CYCLES_PAL(CYCLES_PAL),
    .LINES_NTSC(LINES_NTSC), .LINES_PAL(LINES_PAL),
    .DOTS_PER_PHI(DOTS_PER_PHI), .HSYNC_CYCLES(HSYNC_CYCLES),
    .VSYNC_LINES(VSYNC_LINES)
  ) u_timer (
    .clk_col4x_ntsc, .rst, .chip, .raster, .clk_phi, .phi_fall,
    .hsync(hsync_raw), .vsync(vsync_raw)
  );

  reg_bank u_regs (
    .clk_col4x_ntsc, .rst, .bus(bus_q), .raster, .phi_fall,
    .rdata, .rd_en, .irq_n, .border, .bg
  );

  refresh_gen #(.REFRESH_SLOTS(REFRESH_SLOTS)) u_refresh (
    .clk_col4x_ntsc, .rst, .raster, .ref_addr, .ab_en, .ras
  );

  pixel_out #(
    .DISP_FIRST_LINE(DISP_FIRST_LINE), .DISP_LAST_LINE(DISP_LAST_LINE),
    .DISP_FIRST_CYCLE(DISP_FIRST_CYCLE), .DISP_LAST_CYCLE(DISP_LAST_CYCLE)
  ) u_pixel (
    .clk_col4x_ntsc, .rst, .raster, .hsync(hsync_raw), .vsync(vsync_raw),
    .border, .bg, .video
  );

  // cpu read in phi high, refresh in phi low, never both
  assign dbl = rd_en ? rdata : 8'bz;
  assign adl = ab_en ? ref_addr[5:0] : 6'bz;
  assign adh = ab_en ? ref_addr[11:6] : 6'bz;

  assign active = video.active;
  assign hsync  = video.hsync;
  assign vsync  = video.vsync;
  assign red    = video.red;
  assign green  = video.green;
  assign blue   = video.blue;

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int HALF_NS    = 2,  // 4 ns period
  parameter int RST_CYCLES = 2
) (
  output logic clk_col4x_ntsc,
  output logic rst
);

  initial begin
    clk_col4x_ntsc = 1'b0;
    forever #(HALF_NS) clk_col4x_ntsc = ~clk_col4x_ntsc;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_col4x_ntsc);
    #1 rst = 1'b0;  // released off the edge like the other inputs
  end

endmodule

`default_nettype wire

//--- verif/vic_assert.sv
`timescale 1ns/1ps
`default_nettype none

module vic_assert (
  input logic clk_col4x_ntsc,
  input logic rst,
  input logic rd_en,
  input logic ab_en,
  input logic irq,
  input logic ras,
  input logic clk_phi
);

  // cpu read drive and refresh drive share no clock
  bus_exclusive: assert property (@(posedge clk_col4x_ntsc) disable iff (rst)
    !(rd_en && ab_en))
    else $error("dbl read drive and refresh address drive overlap");

  // interrupt line idle right out of reset
  irq_idle_after_rst: assert property (@(posedge clk_col4x_ntsc)
    rst |=> irq)
    else $error("irq low in the cycle after reset");

  // ras strobes only inside a phi low refresh slot
  ras_in_slot: assert property (@(posedge clk_col4x_ntsc) disable iff (rst)
    !ras |-> ab_en && !clk_phi)
    else $error("ras low outside a refresh slot");

endmodule

bind vic_top vic_assert u_assert (
  .clk_col4x_ntsc(clk_col4x_ntsc),
  .rst(rst),
  .rd_en(rd_en),
  .ab_en(ab_en),
  .irq(irq),
  .ras(ras),
  .clk_phi(clk_phi)
);

`default_nettype wire

//--- verif/tb_vic.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vic;
  import vic_pkg::*;

  localparam int CYC_N = 12;
  localparam int LIN_N = 20;
  localparam int LIN_P = 24;
  localparam int DOTS  = 8;
  localparam int HS_CYC = 4;   // hsync cycles
  localparam int VS_LIN = 3;   // vsync lines
  localparam int TMO    = 6000;  // clocks per wait

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_WAIT} op_e;
  typedef struct packed {
    op_e        op;
    logic [5:0] addr;
    logic [7:0] data;
    logic [7:0] exp;  // expected read value
  } step_t;

  logic clk_col4x_ntsc, rst;
  logic cfg_reset, standard_sw, ce, rw;
  logic bus_oe;         // tb owns adl/dbl
  logic [5:0] adl_drv;
  logic [7:0] dbl_drv;
  wire  [5:0] adl, adh;
  wire  [7:0] dbl;
  logic cpu_reset, clk_phi, irq, ras, hsync, vsync, active;
  logic [5:0] red, green, blue;
  int unsigned edges;   // clocks since reset release
  int n_mismatch, n_other;
  step_t steps [11];
  logic [3:0] rb, rg;   // random border and bg

  tb_clkgen u_clk (.clk_col4x_ntsc, .rst);

  vic_top #(
    .CYCLES_NTSC(CYC_N), .CYCLES_PAL(10), .LINES_NTSC(LIN_N), .LINES_PAL(LIN_P),
    .DOTS_PER_PHI(DOTS), .HSYNC_CYCLES(HS_CYC), .VSYNC_LINES(VS_LIN),
    .DISP_FIRST_LINE(5), .DISP_LAST_LINE(15), .DISP_FIRST_CYCLE(5),
    .DISP_LAST_CYCLE(9), .REFRESH_SLOTS(5)
  ) uut (
    .clk_col4x_ntsc, .rst, .cfg_reset, .standard_sw, .ce, .rw, .adl, .dbl, .adh,
    .cpu_reset, .clk_phi, .irq, .ras, .hsync, .vsync, .active, .red, .green, .blue
  );

  assign adl = bus_oe ? adl_drv : 'z;
  assign dbl = (bus_oe && !rw) ? dbl_drv : 'z;  // released on reads

  // pullups so a floating bus reads as ones
  for (genvar i = 0; i < 8; i++) begin : g_pu_dbl
    pullup (dbl[i]);
  end
  for (genvar i = 0; i < 6; i++) begin : g_pu_ad
    pullup (adl[i]);
    pullup (adh[i]);
  end

  always @(posedge clk_col4x_ntsc) begin
    if (rst) edges <= 0;
    else edges <= edges + 1;
  end

  // raster position after k clocks with the timer leaving reset in phi high
  function automatic int cyc_at(int unsigned k);
    return ((k + DOTS / 2) / DOTS) % CYC_N;
  endfunction

  function automatic int line_at(int unsigned k);
    return (((k + DOTS / 2) / DOTS) / CYC_N) % LIN_N;
  endfunction

  function automatic step_t mk(op_e op, logic [5:0] a, logic [7:0] d, logic [7:0] e);
    return '{op: op, addr: a, data: d, exp: e};
  endfunction

  task automatic tick();
    @(posedge clk_col4x_ntsc);
    #1;
  endtask

  task automatic timeout_seen(input int n, input string what);
    if (n >= TMO) begin
      $display("timeout at %0t while waiting for %s", $time, what);
      n_other++;
    end
  endtask

  // first clock of phi high
  task automatic phi_start();
    int n;
    n = 0;
    while (clk_phi && n < TMO) begin
      tick();
      n++;
    end
    while (!clk_phi && n < TMO) begin
      tick();
      n++;
    end
    timeout_seen(n, "phi high");
  endtask

  task automatic bus_release();
    ce = 1'b1;
    rw = 1'b1;
    bus_oe = 1'b0;
  endtask

  // commit lands on the phi fall three clocks after the drive
  task automatic bus_write(input logic [5:0] a, input logic [7:0] d);
    phi_start();
    ce = 1'b0;
    rw = 1'b0;
    adl_drv = a;
    dbl_drv = d;
    bus_oe = 1'b1;
    repeat (3) tick();
    bus_release();  // off the address lines before refresh can start
    tick();
  endtask

  task automatic bus_read(input logic [5:0] a, output logic [7:0] d, output int ln);
    phi_start();
    ce = 1'b0;
    rw = 1'b1;
    adl_drv = a;
    bus_oe = 1'b1;
    tick();
    ln = line_at(edges);  // line seen when read data is latched
    repeat (2) tick();
    d = dbl;
    bus_release();
    tick();
  endtask

  task automatic wait_line(input int target);
    int n;
    n = 0;
    while (line_at(edges) != target && n < TMO) begin
      tick();
      n++;
    end
    timeout_seen(n, "raster line");
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while (irq !== level && n < TMO) begin
      tick();
      n++;
    end
    timeout_seen(n, "irq level");
  endtask

  // hsync pulses from one vsync rise to the next
  task automatic measure_frame(output int lines);
    int n;
    logic pv, ph;
    n = 0;
    lines = 1;  // hsync rises with vsync
    do begin
      pv = vsync;
      tick();
      n++;
    end while (!(!pv && vsync) && n < TMO);
    do begin
      pv = vsync;
      ph = hsync;
      tick();
      n++;
      if (!ph && hsync && !(!pv && vsync)) lines++;
    end while (!(!pv && vsync) && n < 2 * TMO);
    if (n >= 2 * TMO) begin
      $display("timeout at %0t while measuring a frame", $time);
      n_other++;
    end
  endtask

  task automatic check_video(input int clocks);
    int c, l;
    logic blank;
    logic phi;
    logic [17:0] rgb;
    for (int i = 0; i < clocks; i++) begin
      tick();
      c = cyc_at(edges - 1);  // output lags the raster by one clock
      l = line_at(edges - 1);
      phi = ((edges + DOTS / 2) % DOTS) >= DOTS / 2;  // high in the second half
      blank = (c < HS_CYC) || (l < VS_LIN);
      if (blank) rgb = '0;
      else if (l >= 5 && l <= 15 && c >= 5 && c <= 9) rgb = palette[rg];
      else rgb = palette[rb];
      assert (clk_phi == phi) else begin
        $display("Mismatch at %0t: clk_phi %b expected %b", $time, clk_phi, phi);
        n_mismatch++;
      end
      assert ({active, hsync, vsync} == {!blank, c < HS_CYC, l < VS_LIN}) else begin
        $display("Mismatch at %0t: syncs/active %b at line %0d cycle %0d", $time,
                 {active, hsync, vsync}, l, c);
        n_mismatch++;
      end
      assert ({red, green, blue} == rgb) else begin
        $display("Mismatch at %0t: rgb %h expected %h at line %0d cycle %0d", $time,
                 {red, green, blue}, rgb, l, c);
        n_mismatch++;
      end
    end
  endtask

  initial begin
    logic [7:0] d;
    logic [7:0] prev;
    logic [11:0] a;
    logic pr;
    int ln, n, lines;
    ce = 1'b1;
    rw = 1'b1;
    bus_oe = 1'b0;
    adl_drv = '0;
    dbl_drv = '0;
    cfg_reset = 1'b0;
    standard_sw = 1'b0;
    n_mismatch = 0;
    n_other = 0;
    void'($urandom(32));
    rb = 4'($urandom % 16);
    rg = 4'($urandom % 16);
    if (rg == rb) rg = rb + 4'd1;  // keep window and border apart

    steps[0]  = mk(OP_WRITE, REG_BORDER, {4'h0, rb}, 8'h00);
    steps[1]  = mk(OP_WRITE, REG_BG0, {4'ha, rg}, 8'h00);  // upper nibble ignored
    steps[2]  = mk(OP_READ, REG_BORDER, 8'h00, {4'hf, rb});
    steps[3]  = mk(OP_READ, REG_BG0, 8'h00, {4'hf, rg});
    steps[4]  = mk(OP_WRITE, REG_IRQ_ENABLE, 8'h01, 8'h00);
    steps[5]  = mk(OP_READ, REG_IRQ_ENABLE, 8'h00, 8'hff);
    steps[6]  = mk(OP_READ, 6'h3f, 8'h00, 8'hff);  // unmapped
    steps[7]  = mk(OP_READ, 6'h00, 8'h00, 8'hff);
    steps[8]  = mk(OP_READ, REG_CTRL1, 8'h00, 8'h7f);
    steps[9]  = mk(OP_WAIT, 6'h00, 8'd4, 8'h00);
    steps[10] = mk(OP_READ, REG_RASTER, 8'h00, 8'h00);  // expect is the line

    tick();
    assert (cpu_reset === 1'b1) else begin
      $display("Mismatch at %0t: cpu_reset %b during reset", $time, cpu_reset);
      n_mismatch++;
    end

    n = 0;
    while (rst && n < TMO) begin
      tick();
      n++;
    end
    timeout_seen(n, "reset release");

    // bus floats to the pullups after reset
    assert (irq === 1'b1 && active === 1'b0) else begin
      $display("Mismatch at %0t: irq %b active %b after reset", $time, irq, active);
      n_mismatch++;
    end
    assert (dbl === 8'hff && adl === 6'h3f) else begin
      $display("Mismatch at %0t: bus driven after reset dbl %h adl %h", $time, dbl, adl);
      n_mismatch++;
    end
    bus_read(REG_CTRL1, d, ln);
    assert (d[7] == 1'b0) else begin
      $display("Mismatch at %0t: ctrl1 bit 7 set after reset", $time);
      n_mismatch++;
    end
    assert (cpu_reset === 1'b0) else begin
      $display("Mismatch at %0t: cpu_reset %b after reset", $time, cpu_reset);
      n_mismatch++;
    end

    foreach (steps[i]) begin
      case (steps[i].op)
        OP_WRITE: bus_write(steps[i].addr, steps[i].data);
        OP_WAIT:  wait_line(int'(steps[i].data));
        default: begin
          bus_read(steps[i].addr, d, ln);
          if (steps[i].addr == REG_RASTER) steps[i].exp = 8'(ln);
          assert (d == steps[i].exp) else begin
            $display("Mismatch at %0t: step %0d addr %h read %h expected %h", $time,
                     i, steps[i].addr, d, steps[i].exp);
            n_mismatch++;
          end
        end
      endcase
    end

    // raster interrupt on line 7
    bus_write(REG_RASTER, 8'd7);
    bus_write(REG_CTRL1, 8'h00);
    bus_write(REG_IRQ_STATUS, 8'h01);  // drop any stale flag
    bus_write(REG_IRQ_ENABLE, 8'h01);
    wait_irq(1'b0);
    assert (line_at(edges) == 7) else begin
      $display("Mismatch at %0t: irq on line %0d", $time, line_at(edges));
      n_mismatch++;
    end
    bus_read(REG_IRQ_STATUS, d, ln);
    assert ((d & 8'h81) == 8'h81) else begin
      $display("Mismatch at %0t: irq status %h", $time, d);
      n_mismatch++;
    end
    bus_write(REG_IRQ_STATUS, 8'h01);
    wait_irq(1'b1);
    bus_read(REG_IRQ_STATUS, d, ln);
    assert ((d & 8'h81) == 8'h00) else begin
      $display("Mismatch at %0t: irq status %h after clear", $time, d);
      n_mismatch++;
    end
    bus_write(REG_IRQ_ENABLE, 8'h00);

    check_video(2 * LIN_N * CYC_N * DOTS);

    // refresh rows step by one per slot
    prev = '0;
    for (int s = 0; s < 12; s++) begin
      n = 0;
      do begin
        pr = ras;
        tick();
        n++;
      end while (!(pr && !ras) && n < TMO);
      timeout_seen(n, "refresh slot");
      a = {adh, adl};
      assert (a[11:8] == 4'hf && (s == 0 || a[7:0] == prev + 8'd1)) else begin
        $display("Mismatch at %0t: refresh address %h after row %h", $time, a, prev);
        n_mismatch++;
      end
      prev = a[7:0];
    end

    // chip model by lines per frame
    measure_frame(lines);
    assert (lines == LIN_N) else begin
      $display("Mismatch at %0t: ntsc frame has %0d lines", $time, lines);
      n_mismatch++;
    end
    standard_sw = 1'b1;
    repeat (4) tick();
    standard_sw = 1'b0;
    measure_frame(lines);  // may still be the old frame
    measure_frame(lines);
    assert (lines == LIN_P) else begin
      $display("Mismatch at %0t: pal frame has %0d lines", $time, lines);
      n_mismatch++;
    end
    cfg_reset = 1'b1;
    repeat (4) tick();
    cfg_reset = 1'b0;
    measure_frame(lines);
    measure_frame(lines);
    assert (lines == LIN_N) else begin
      $display("Mismatch at %0t: frame after cfg_reset has %0d lines", $time, lines);
      n_mismatch++;
    end

    $display("errors: mismatch %0d, other %0d", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
src/vic_pkg.sv
src/chip_select.sv
src/raster_timer.sv
src/reg_bank.sv
src/refresh_gen.sv
src/pixel_out.sv
src/vic_top.sv
verif/tb_clkgen.sv
verif/vic_assert.sv
verif/tb_vic.sv

//--- Makefile
SIM := obj_dir/Vtb_vic
SRCS := $(wildcard src/*.sv verif/*.sv)

.PHONY: all run clean

all: run

$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_vic -f tb.f -o Vtb_vic

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
